// ==== filelist.f ====
+incdir+tb
logic/wb_pkg.sv
logic/load_aligner.sv
logic/rollback_arbiter.sv
logic/writeback_register.sv
logic/writeback_stage.sv
tb/tb_writeback_stage.sv

// ==== logic/load_aligner.sv ====
////////////////////////////////////////////////////////////
// Load result formatting for the writeback stage. Merges
// pending store-buffer bytes into the cache line and returns
// the addressed byte, halfword or word, extended to 32 bits.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module load_aligner(
	input logic [wb_pkg::line_bits-1:0] dd_load_data,
	input logic [wb_pkg::line_bytes-1:0] sq_bypass_mask,
	input logic [wb_pkg::line_bits-1:0] sq_bypass_data,
	input logic [wb_pkg::line_offset_width-1:0] dd_offset,
	input wb_pkg::mem_op_t dd_mem_op,
	output wb_pkg::scalar_t load_value);

	import wb_pkg::*;

	logic [line_bits-1:0] merged_line;
	logic [line_offset_width-3:0] word_idx;
	scalar_t lane;
	logic [7:0] byte_value;
	logic [15:0] half_value;
	scalar_t word_value;

	// Store-buffer bytes not yet in the cache take precedence
	genvar byte_lane;
	generate
		for (byte_lane = 0; byte_lane < line_bytes; byte_lane++)
		begin : bypass_gen
			assign merged_line[byte_lane*8 +: 8] = sq_bypass_mask[byte_lane]
				? sq_bypass_data[byte_lane*8 +: 8] : dd_load_data[byte_lane*8 +: 8];
		end
	endgenerate

	// Memory word 0 sits in the top bus word, so invert the word index
	assign word_idx = ~dd_offset[line_offset_width-1:2];
	assign lane = merged_line[word_idx*32 +: 32];

	// Lowest address byte of the lane is in its top bits
	always_comb
	begin
		case (dd_offset[1:0])
			2'b00: byte_value = lane[31:24];
			2'b01: byte_value = lane[23:16];
			2'b10: byte_value = lane[15:8];
			default: byte_value = lane[7:0];
		endcase
	end

	// Halfword is little-endian, second byte goes high
	assign half_value = dd_offset[1] ? {lane[7:0], lane[15:8]} : {lane[23:16], lane[31:24]};

	// Full byte reversal for a word load
	assign word_value = {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};

	// Width select and extension
	always_comb
	begin
		case (dd_mem_op)
			mem_b: load_value = {{(data_width-8){1'b0}}, byte_value};
			mem_bx: load_value = {{(data_width-8){byte_value[7]}}, byte_value};
			mem_s: load_value = {{(data_width-16){1'b0}}, half_value};
			mem_sx: load_value = {{(data_width-16){half_value[15]}}, half_value};
			mem_l: load_value = word_value;
			// Unused encodings behave as a word load
			default: load_value = word_value;
		endcase
	end

endmodule

// ==== logic/rollback_arbiter.sv ====
////////////////////////////////////////////////////////////
// Picks the one rollback of the cycle by fixed priority and
// reports faults. Also builds the thread suspend mask for
// cache misses and a full store buffer. Purely combinational.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rollback_arbiter(
	input logic sx_valid,
	input logic sx_illegal,
	input logic sx_has_dest,
	input wb_pkg::register_idx_t sx_dest_reg,
	input wb_pkg::scalar_t sx_pc,
	input wb_pkg::scalar_t sx_result,
	input wb_pkg::thread_idx_t sx_thread_idx,
	input logic sx_rollback_en,
	input wb_pkg::scalar_t sx_rollback_pc,
	input logic dd_valid,
	input logic dd_is_load,
	input logic dd_has_dest,
	input wb_pkg::register_idx_t dd_dest_reg,
	input wb_pkg::scalar_t dd_pc,
	input wb_pkg::thread_idx_t dd_thread_idx,
	input logic dd_rollback_en,
	input wb_pkg::scalar_t dd_rollback_pc,
	input logic dd_access_fault,
	input logic dd_suspend_thread,
	input logic sq_full_rollback_en,
	input wb_pkg::scalar_t load_value,
	output logic wb_rollback_en,
	output wb_pkg::thread_idx_t wb_rollback_thread_idx,
	output wb_pkg::scalar_t wb_rollback_pc,
	output wb_pkg::pipeline_sel_t wb_rollback_pipeline,
	output logic wb_fault,
	output wb_pkg::fault_reason_t wb_fault_reason,
	output wb_pkg::scalar_t wb_fault_address,
	output logic [wb_pkg::threads_per_core-1:0] wb_suspend_thread_oh);

	import wb_pkg::*;

	logic sx_writes_pc;
	logic dd_loads_pc;
	logic [threads_per_core-1:0] thread_oh;

	// PC destination on either pipeline acts as a jump
	assign sx_writes_pc = sx_has_dest && sx_dest_reg == reg_pc;

	// A missed load has no data yet, so the miss rollback wins
	assign dd_loads_pc = dd_is_load && dd_has_dest && dd_dest_reg == reg_pc && !dd_rollback_en;

	always_comb
	begin
		wb_rollback_en = 1'b0;
		wb_rollback_thread_idx = '0;
		wb_rollback_pc = '0;
		wb_rollback_pipeline = pipe_scycle_arith;
		wb_fault = 1'b0;
		wb_fault_reason = fr_none;
		wb_fault_address = '0;

		if (sx_valid && sx_illegal)
		begin
			// Illegal instruction trap
			wb_rollback_en = 1'b1;
			wb_rollback_thread_idx = sx_thread_idx;
			wb_rollback_pc = fault_vector_pc;
			wb_rollback_pipeline = pipe_scycle_arith;
			wb_fault = 1'b1;
			wb_fault_reason = fr_illegal_instruction;
			wb_fault_address = sx_pc;
		end
		else if (dd_valid && dd_access_fault)
		begin
			// Bad data access trap
			wb_rollback_en = 1'b1;
			wb_rollback_thread_idx = dd_thread_idx;
			wb_rollback_pc = fault_vector_pc;
			wb_rollback_pipeline = pipe_mem;
			wb_fault = 1'b1;
			wb_fault_reason = fr_invalid_access;
			wb_fault_address = dd_pc;
		end
		else if (sx_valid && sx_writes_pc)
		begin
			// Arithmetic result is the new PC
			wb_rollback_en = 1'b1;
			wb_rollback_thread_idx = sx_thread_idx;
			wb_rollback_pc = sx_result;
			wb_rollback_pipeline = pipe_scycle_arith;
		end
		else if (dd_valid && dd_loads_pc)
		begin
			// Loaded value is the new PC
			wb_rollback_en = 1'b1;
			wb_rollback_thread_idx = dd_thread_idx;
			wb_rollback_pc = load_value;
			wb_rollback_pipeline = pipe_mem;
		end
		else if (sx_valid)
		begin
			// Taken branch
			wb_rollback_en = sx_rollback_en;
			wb_rollback_thread_idx = sx_thread_idx;
			wb_rollback_pc = sx_rollback_pc;
			wb_rollback_pipeline = pipe_scycle_arith;
		end
		else if (dd_valid)
		begin
			// Cache miss or store buffer full, replay the instruction
			wb_rollback_en = dd_rollback_en || sq_full_rollback_en;
			wb_rollback_thread_idx = dd_thread_idx;
			wb_rollback_pc = dd_rollback_pc;
			wb_rollback_pipeline = pipe_mem;
		end
	end

	// Thread waits for the fill or for store buffer space
	assign thread_oh = threads_per_core'(1) << dd_thread_idx;
	assign wb_suspend_thread_oh = (dd_suspend_thread || sq_full_rollback_en) ? thread_oh : '0;

endmodule

// ==== logic/wb_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, register indexes and enums for the integer
// writeback stage. Modules refer to these by scoped names in
// their port lists and import the package inside the body.
////////////////////////////////////////////////////////////

package wb_pkg;

	// Scalar register value and PC
	localparam int data_width = 32;
	typedef logic [data_width-1:0] scalar_t;

	// Data cache line geometry
	localparam int line_bytes = 16;
	localparam int line_bits = line_bytes * 8;
	localparam int line_offset_width = $clog2(line_bytes);

	// Hardware threads per core
	localparam int threads_per_core = 4;
	typedef logic [$clog2(threads_per_core)-1:0] thread_idx_t;

	// Integer register file index
	typedef logic [4:0] register_idx_t;

	// Writing this register redirects the thread
	localparam register_idx_t reg_pc = 5'd31;

	// Entry point of the fault handler
	localparam scalar_t fault_vector_pc = 32'd4;

	// Scalar load widths, x variants sign-extend
	typedef enum logic [2:0]
	{
		mem_b,
		mem_bx,
		mem_s,
		mem_sx,
		mem_l
	} mem_op_t;

	// Pipeline that issued the rollback
	typedef enum logic
	{
		pipe_scycle_arith,
		pipe_mem
	} pipeline_sel_t;

	// Cause reported with a fault
	typedef enum logic [1:0]
	{
		fr_none,
		fr_illegal_instruction,
		fr_invalid_access
	} fault_reason_t;

endpackage

// ==== logic/writeback_register.sv ====
////////////////////////////////////////////////////////////
// Register-file write port of the writeback stage. Takes the
// result of whichever pipeline retires this cycle and presents
// the write one clock later.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module writeback_register(
	input logic clk,
	input logic reset,
	input logic sx_valid,
	input logic sx_has_dest,
	input logic sx_is_call,
	input wb_pkg::register_idx_t sx_dest_reg,
	input wb_pkg::scalar_t sx_result,
	input wb_pkg::thread_idx_t sx_thread_idx,
	input logic dd_valid,
	input logic dd_is_load,
	input logic dd_has_dest,
	input wb_pkg::register_idx_t dd_dest_reg,
	input wb_pkg::thread_idx_t dd_thread_idx,
	input wb_pkg::scalar_t load_value,
	input logic wb_rollback_en,
	output logic wb_writeback_en,
	output wb_pkg::thread_idx_t wb_writeback_thread_idx,
	output wb_pkg::register_idx_t wb_writeback_reg,
	output wb_pkg::scalar_t wb_writeback_value);

	logic sx_write;
	logic dd_write;

	// Call writes the link register even though it also rolls back
	assign sx_write = sx_is_call || (sx_has_dest && !wb_rollback_en);

	// Stores and missed or faulted loads leave the register file alone
	assign dd_write = dd_is_load && dd_has_dest && !wb_rollback_en;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb_writeback_en <= 1'b0;
			wb_writeback_thread_idx <= '0;
			wb_writeback_reg <= '0;
			wb_writeback_value <= '0;
		end
		else
		begin
			if (sx_valid)
			begin
				// Single-cycle arithmetic result
				wb_writeback_en <= sx_write;
				wb_writeback_thread_idx <= sx_thread_idx;
				wb_writeback_reg <= sx_dest_reg;
				wb_writeback_value <= sx_result;
			end
			else if (dd_valid)
			begin
				// Aligned load data
				wb_writeback_en <= dd_write;
				wb_writeback_thread_idx <= dd_thread_idx;
				wb_writeback_reg <= dd_dest_reg;
				wb_writeback_value <= load_value;
			end
			else
			begin
				// Nothing retires, payload holds
				wb_writeback_en <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/writeback_stage.sv ====
////////////////////////////////////////////////////////////
// Integer writeback stage of the in-order core. Rollback,
// fault and suspend outputs are combinational with the input
// strobe; the register-file write follows one clock later.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module writeback_stage(
	input logic clk,
	input logic reset,

	// Single-cycle arithmetic pipeline
	input logic sx_valid,
	input wb_pkg::scalar_t sx_pc,
	input wb_pkg::thread_idx_t sx_thread_idx,
	input wb_pkg::scalar_t sx_result,
	input logic sx_illegal,
	input logic sx_has_dest,
	input wb_pkg::register_idx_t sx_dest_reg,
	input logic sx_is_call,
	input logic sx_rollback_en,
	input wb_pkg::scalar_t sx_rollback_pc,

	// Data cache load pipeline
	input logic dd_valid,
	input wb_pkg::scalar_t dd_pc,
	input wb_pkg::thread_idx_t dd_thread_idx,
	input logic dd_is_load,
	input logic dd_has_dest,
	input wb_pkg::register_idx_t dd_dest_reg,
	input wb_pkg::mem_op_t dd_mem_op,
	input logic [wb_pkg::line_offset_width-1:0] dd_offset,
	input logic [wb_pkg::line_bits-1:0] dd_load_data,
	input logic dd_rollback_en,
	input wb_pkg::scalar_t dd_rollback_pc,
	input logic dd_suspend_thread,
	input logic dd_access_fault,

	// Store buffer
	input logic [wb_pkg::line_bytes-1:0] sq_bypass_mask,
	input logic [wb_pkg::line_bits-1:0] sq_bypass_data,
	input logic sq_full_rollback_en,

	// Rollback and fault, same cycle
	output logic wb_rollback_en,
	output wb_pkg::thread_idx_t wb_rollback_thread_idx,
	output wb_pkg::scalar_t wb_rollback_pc,
	output wb_pkg::pipeline_sel_t wb_rollback_pipeline,
	output logic wb_fault,
	output wb_pkg::fault_reason_t wb_fault_reason,
	output wb_pkg::scalar_t wb_fault_address,
	output logic [wb_pkg::threads_per_core-1:0] wb_suspend_thread_oh,

	// Register-file write, next cycle
	output logic wb_writeback_en,
	output wb_pkg::thread_idx_t wb_writeback_thread_idx,
	output wb_pkg::register_idx_t wb_writeback_reg,
	output wb_pkg::scalar_t wb_writeback_value);

	import wb_pkg::*;

	// Aligned load result, feeds both the PC load and the write
	scalar_t load_value;

	load_aligner i_load_aligner(
		.dd_load_data(dd_load_data),
		.sq_bypass_mask(sq_bypass_mask),
		.sq_bypass_data(sq_bypass_data),
		.dd_offset(dd_offset),
		.dd_mem_op(dd_mem_op),
		.load_value(load_value));

	rollback_arbiter i_rollback_arbiter(
		.sx_valid(sx_valid),
		.sx_illegal(sx_illegal),
		.sx_has_dest(sx_has_dest),
		.sx_dest_reg(sx_dest_reg),
		.sx_pc(sx_pc),
		.sx_result(sx_result),
		.sx_thread_idx(sx_thread_idx),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc),
		.dd_valid(dd_valid),
		.dd_is_load(dd_is_load),
		.dd_has_dest(dd_has_dest),
		.dd_dest_reg(dd_dest_reg),
		.dd_pc(dd_pc),
		.dd_thread_idx(dd_thread_idx),
		.dd_rollback_en(dd_rollback_en),
		.dd_rollback_pc(dd_rollback_pc),
		.dd_access_fault(dd_access_fault),
		.dd_suspend_thread(dd_suspend_thread),
		.sq_full_rollback_en(sq_full_rollback_en),
		.load_value(load_value),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.wb_rollback_pc(wb_rollback_pc),
		.wb_rollback_pipeline(wb_rollback_pipeline),
		.wb_fault(wb_fault),
		.wb_fault_reason(wb_fault_reason),
		.wb_fault_address(wb_fault_address),
		.wb_suspend_thread_oh(wb_suspend_thread_oh));

	// Rollback squashes the write of the retiring instruction
	writeback_register i_writeback_register(
		.clk(clk),
		.reset(reset),
		.sx_valid(sx_valid),
		.sx_has_dest(sx_has_dest),
		.sx_is_call(sx_is_call),
		.sx_dest_reg(sx_dest_reg),
		.sx_result(sx_result),
		.sx_thread_idx(sx_thread_idx),
		.dd_valid(dd_valid),
		.dd_is_load(dd_is_load),
		.dd_has_dest(dd_has_dest),
		.dd_dest_reg(dd_dest_reg),
		.dd_thread_idx(dd_thread_idx),
		.load_value(load_value),
		.wb_rollback_en(wb_rollback_en),
		.wb_writeback_en(wb_writeback_en),
		.wb_writeback_thread_idx(wb_writeback_thread_idx),
		.wb_writeback_reg(wb_writeback_reg),
		.wb_writeback_value(wb_writeback_value));

endmodule

// ==== tb/wb_model.svh ====
////////////////////////////////////////////////////////////
// Reference model of the writeback stage. Included in the
// testbench module body after its stimulus signals, which the
// model functions read to compute the expected outputs.
////////////////////////////////////////////////////////////

`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

// Expected rollback and fault of one cycle
typedef struct packed
{
	logic en;
	thread_idx_t thread_idx;
	scalar_t pc;
	pipeline_sel_t pipeline;
	logic fault;
	fault_reason_t reason;
	scalar_t address;
} rollback_t;

// Expected register-file write
typedef struct packed
{
	logic en;
	thread_idx_t thread_idx;
	register_idx_t dest;
	scalar_t value;
} writeback_t;

// Pseudo-random step, 13/17/5 shifts
function automatic logic [31:0] xorshift(input logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Scalar load value from the line, the store bytes and the offset
function automatic scalar_t model_load(input logic [line_bits-1:0] line,
	input logic [line_bytes-1:0] mask, input logic [line_bits-1:0] bypass,
	input int offset, input mem_op_t op);
	logic [31:0] gathered;
	int bus_byte;
	scalar_t value;
	// Memory byte a lives in bus byte 15 - a, assembled little-endian
	for (int i = 0; i < 4; i++)
	begin
		bus_byte = line_bytes - 1 - ((offset + i) % line_bytes);
		gathered[i*8 +: 8] = mask[bus_byte] ? bypass[bus_byte*8 +: 8]
			: line[bus_byte*8 +: 8];
	end
	case (op)
		mem_b: value = {24'h0, gathered[7:0]};
		mem_bx: value = {{24{gathered[7]}}, gathered[7:0]};
		mem_s: value = {16'h0, gathered[15:0]};
		mem_sx: value = {{16{gathered[15]}}, gathered[15:0]};
		default: value = gathered;
	endcase
	return value;
endfunction

// Fixed priority, first matching rule wins
function automatic rollback_t model_rollback();
	rollback_t r;
	r = '0;
	if (sx_valid && sx_illegal)
	begin
		r.en = 1'b1;
		r.thread_idx = sx_thread_idx;
		r.pc = fault_vector_pc;
		r.pipeline = pipe_scycle_arith;
		r.fault = 1'b1;
		r.reason = fr_illegal_instruction;
		r.address = sx_pc;
	end
	else if (dd_valid && dd_access_fault)
	begin
		r.en = 1'b1;
		r.thread_idx = dd_thread_idx;
		r.pc = fault_vector_pc;
		r.pipeline = pipe_mem;
		r.fault = 1'b1;
		r.reason = fr_invalid_access;
		r.address = dd_pc;
	end
	else if (sx_valid && sx_has_dest && sx_dest_reg == reg_pc)
	begin
		r.en = 1'b1;
		r.thread_idx = sx_thread_idx;
		r.pc = sx_result;
		r.pipeline = pipe_scycle_arith;
	end
	else if (dd_valid && dd_is_load && dd_has_dest && dd_dest_reg == reg_pc
		&& !dd_rollback_en)
	begin
		// Jump target is the aligned load value
		r.en = 1'b1;
		r.thread_idx = dd_thread_idx;
		r.pc = model_load(dd_load_data, sq_bypass_mask, sq_bypass_data, dd_offset,
			dd_mem_op);
		r.pipeline = pipe_mem;
	end
	else if (sx_valid)
	begin
		r.en = sx_rollback_en;
		r.thread_idx = sx_thread_idx;
		r.pc = sx_rollback_pc;
		r.pipeline = pipe_scycle_arith;
	end
	else if (dd_valid)
	begin
		r.en = dd_rollback_en || sq_full_rollback_en;
		r.thread_idx = dd_thread_idx;
		r.pc = dd_rollback_pc;
		r.pipeline = pipe_mem;
	end
	return r;
endfunction

// Write that the current inputs should produce one clock later
function automatic writeback_t model_writeback(input logic rollback_en);
	writeback_t w;
	w = '0;
	if (sx_valid)
	begin
		w.en = sx_is_call || (sx_has_dest && !rollback_en);
		w.thread_idx = sx_thread_idx;
		w.dest = sx_dest_reg;
		w.value = sx_result;
	end
	else if (dd_valid)
	begin
		w.en = dd_is_load && dd_has_dest && !rollback_en;
		w.thread_idx = dd_thread_idx;
		w.dest = dd_dest_reg;
		w.value = model_load(dd_load_data, sq_bypass_mask, sq_bypass_data, dd_offset,
			dd_mem_op);
	end
	return w;
endfunction

// One-hot thread mask for a miss or a full store buffer
function automatic logic [threads_per_core-1:0] model_suspend();
	logic [threads_per_core-1:0] mask;
	mask = '0;
	if (dd_suspend_thread || sq_full_rollback_en)
		mask[dd_thread_idx] = 1'b1;
	return mask;
endfunction

`endif

// ==== tb/tb_writeback_stage.sv ====
////////////////////////////////////////////////////////////
// Testbench for the writeback stage. Drives directed and
// random strobes on the falling edge and compares every cycle
// against the included reference model.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_writeback_stage;

	import wb_pkg::*;

	logic clk;
	logic reset;

	// Single-cycle pipeline
	logic sx_valid;
	scalar_t sx_pc;
	thread_idx_t sx_thread_idx;
	scalar_t sx_result;
	logic sx_illegal;
	logic sx_has_dest;
	register_idx_t sx_dest_reg;
	logic sx_is_call;
	logic sx_rollback_en;
	scalar_t sx_rollback_pc;

	// Data cache
	logic dd_valid;
	scalar_t dd_pc;
	thread_idx_t dd_thread_idx;
	logic dd_is_load;
	logic dd_has_dest;
	register_idx_t dd_dest_reg;
	mem_op_t dd_mem_op;
	logic [line_offset_width-1:0] dd_offset;
	logic [line_bits-1:0] dd_load_data;
	logic dd_rollback_en;
	scalar_t dd_rollback_pc;
	logic dd_suspend_thread;
	logic dd_access_fault;

	// Store buffer
	logic [line_bytes-1:0] sq_bypass_mask;
	logic [line_bits-1:0] sq_bypass_data;
	logic sq_full_rollback_en;

	// DUT outputs
	logic wb_rollback_en;
	thread_idx_t wb_rollback_thread_idx;
	scalar_t wb_rollback_pc;
	pipeline_sel_t wb_rollback_pipeline;
	logic wb_fault;
	fault_reason_t wb_fault_reason;
	scalar_t wb_fault_address;
	logic [threads_per_core-1:0] wb_suspend_thread_oh;
	logic wb_writeback_en;
	thread_idx_t wb_writeback_thread_idx;
	register_idx_t wb_writeback_reg;
	scalar_t wb_writeback_value;

	// Bookkeeping shared by stimulus and checker
	int checks = 0;
	int errors = 0;
	int driven = 0;
	int checked = 0;
	int test_checks;
	int test_errors;
	logic [31:0] rng_state = 32'hfc3cbb92;

	`include "wb_model.svh"

	writeback_stage i_dut(.*);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	function automatic logic [31:0] rand_word();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [line_bits-1:0] rand_line();
		logic [line_bits-1:0] line;
		for (int i = 0; i < line_bits / 32; i++)
			line[i*32 +: 32] = rand_word();
		return line;
	endfunction

	task automatic check_rollback(input logic en, input thread_idx_t thread_idx,
		input scalar_t pc, input pipeline_sel_t pipeline, input rollback_t expected);
		checks++;
		// Target fields only matter when a rollback is expected
		if (en !== expected.en || (expected.en && (thread_idx !== expected.thread_idx
			|| pc !== expected.pc || pipeline !== expected.pipeline)))
		begin
			errors++;
			$display("Fail at %0t: rollback en %b t%0d pc %h pipe %0d, expected en %b t%0d pc %h pipe %0d",
				$time, en, thread_idx, pc, pipeline, expected.en, expected.thread_idx,
				expected.pc, expected.pipeline);
		end
	endtask

	task automatic check_fault(input logic fault, input fault_reason_t reason,
		input scalar_t address, input rollback_t expected);
		checks++;
		if (fault !== expected.fault || (expected.fault && (reason !== expected.reason
			|| address !== expected.address)))
		begin
			errors++;
			$display("Fail at %0t: fault %b reason %0d addr %h, expected %b reason %0d addr %h",
				$time, fault, reason, address, expected.fault, expected.reason,
				expected.address);
		end
	endtask

	task automatic check_suspend(input logic [threads_per_core-1:0] mask,
		input logic [threads_per_core-1:0] expected);
		checks++;
		if (mask !== expected)
		begin
			errors++;
			$display("Fail at %0t: suspend mask %b, expected %b", $time, mask, expected);
		end
	endtask

	task automatic check_writeback(input logic en, input thread_idx_t thread_idx,
		input register_idx_t dest, input scalar_t value, input writeback_t expected);
		checks++;
		// Payload is only meaningful with the enable set
		if (en !== expected.en || (expected.en && (thread_idx !== expected.thread_idx
			|| dest !== expected.dest || value !== expected.value)))
		begin
			errors++;
			$display("Fail at %0t: writeback en %b t%0d r%0d %h, expected en %b t%0d r%0d %h",
				$time, en, thread_idx, dest, value, expected.en, expected.thread_idx,
				expected.dest, expected.value);
		end
	endtask

	task automatic clear_inputs();
		sx_valid = 1'b0;
		sx_pc = '0;
		sx_thread_idx = '0;
		sx_result = '0;
		sx_illegal = 1'b0;
		sx_has_dest = 1'b0;
		sx_dest_reg = '0;
		sx_is_call = 1'b0;
		sx_rollback_en = 1'b0;
		sx_rollback_pc = '0;
		dd_valid = 1'b0;
		dd_pc = '0;
		dd_thread_idx = '0;
		dd_is_load = 1'b0;
		dd_has_dest = 1'b0;
		dd_dest_reg = '0;
		dd_mem_op = mem_b;
		dd_offset = '0;
		dd_load_data = '0;
		dd_rollback_en = 1'b0;
		dd_rollback_pc = '0;
		dd_suspend_thread = 1'b0;
		dd_access_fault = 1'b0;
		sq_bypass_mask = '0;
		sq_bypass_data = '0;
		sq_full_rollback_en = 1'b0;
	endtask

	// New input cycle starts on the falling edge
	task automatic begin_cycle();
		@(negedge clk);
		clear_inputs();
		driven++;
	endtask

	task automatic random_sx();
		logic [31:0] r;
		r = rand_word();
		sx_valid = 1'b1;
		sx_pc = rand_word();
		sx_thread_idx = r[1:0];
		sx_result = rand_word();
		sx_illegal = r[4:2] == 3'd0;
		sx_has_dest = r[5];
		// Bias toward the PC register so jumps show up often
		sx_dest_reg = r[7:6] == 2'd0 ? reg_pc : r[12:8];
		sx_is_call = r[14:13] == 2'd0;
		sx_rollback_en = r[15];
		sx_rollback_pc = rand_word();
	endtask

	task automatic random_dd(input logic clean);
		logic [31:0] r;
		logic [31:0] s;
		r = rand_word();
		dd_valid = 1'b1;
		dd_pc = rand_word();
		dd_thread_idx = r[1:0];
		dd_mem_op = mem_op_t'(rand_word() % 5);
		// Natural alignment for halfword and word loads
		case (dd_mem_op)
			mem_s, mem_sx: dd_offset = r[5:2] & 4'he;
			mem_l: dd_offset = r[5:2] & 4'hc;
			default: dd_offset = r[5:2];
		endcase
		dd_load_data = rand_line();
		sq_bypass_mask = r[21:6];
		sq_bypass_data = rand_line();
		dd_rollback_pc = rand_word();
		if (clean)
		begin
			// Plain load into a general register
			dd_is_load = 1'b1;
			dd_has_dest = 1'b1;
			dd_dest_reg = register_idx_t'(r[26:22] % 5'd31);
		end
		else
		begin
			s = rand_word();
			dd_is_load = s[1:0] != 2'd0;
			dd_has_dest = s[2];
			dd_dest_reg = s[4:3] == 2'd0 ? reg_pc : s[9:5];
			dd_rollback_en = s[11:10] == 2'd0;
			dd_suspend_thread = dd_rollback_en && s[12];
			dd_access_fault = s[15:13] == 3'd0;
			sq_full_rollback_en = s[18:16] == 3'd0;
		end
	endtask

	task automatic start_test();
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		int guard;
		// Idle cycle lets the last write reach the checker
		begin_cycle();
		guard = 0;
		while (checked < driven)
		begin
			@(negedge clk);
			guard++;
			if (guard > 10)
			begin
				$display("Timeout: checker stopped following the stimulus in test %s", name);
				$display("STATUS: FAIL");
				$finish;
			end
		end
		$display("Test %s: %0d checks, %0d errors", name, checks - test_checks,
			errors - test_errors);
	endtask

	// Compares just before each rising edge, writes one cycle late
	initial
	begin : compare
		rollback_t expected_rb;
		writeback_t pending_wb;
		int guard;
		guard = 0;
		pending_wb = '0;
		while (reset !== 1'b0)
		begin
			@(negedge clk);
			#1;
			guard++;
			if (guard > 20)
			begin
				$display("Timeout: reset was never released");
				$display("STATUS: FAIL");
				$finish;
			end
		end
		forever
		begin
			@(negedge clk);
			#9;
			expected_rb = model_rollback();
			check_rollback(wb_rollback_en, wb_rollback_thread_idx, wb_rollback_pc,
				wb_rollback_pipeline, expected_rb);
			check_fault(wb_fault, wb_fault_reason, wb_fault_address, expected_rb);
			check_suspend(wb_suspend_thread_oh, model_suspend());
			check_writeback(wb_writeback_en, wb_writeback_thread_idx, wb_writeback_reg,
				wb_writeback_value, pending_wb);
			pending_wb = model_writeback(expected_rb.en);
			checked = driven;
		end
	end

	initial
	begin : stimulus
		int step;
		mem_op_t op_sel;
		clear_inputs();
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		start_test();
		// Write port leaves reset idle and cleared
		checks++;
		if (wb_writeback_en !== 1'b0 || wb_writeback_thread_idx !== '0
			|| wb_writeback_reg !== '0 || wb_writeback_value !== '0)
		begin
			errors++;
			$display("Fail at %0t: writeback port not cleared by reset", $time);
		end
		begin_cycle();
		sx_valid = 1'b1;
		sx_pc = 32'h40;
		sx_thread_idx = 2'd2;
		sx_result = 32'h1234_5678;
		sx_has_dest = 1'b1;
		sx_dest_reg = 5'd7;
		// Compare with no destination
		begin_cycle();
		sx_valid = 1'b1;
		sx_pc = 32'h44;
		sx_thread_idx = 2'd1;
		sx_result = 32'hdead_beef;
		sx_dest_reg = 5'd9;
		finish_test("reset and arithmetic writeback");

		start_test();
		// Every width at every legal offset, then free random loads
		for (int pass = 0; pass < 3; pass++)
			for (int op = 0; op < 5; op++)
			begin
				op_sel = mem_op_t'(op);
				step = op_sel == mem_l ? 4 : (op_sel == mem_s || op_sel == mem_sx) ? 2 : 1;
				for (int off = 0; off < line_bytes; off += step)
				begin
					begin_cycle();
					random_dd(1'b1);
					dd_mem_op = op_sel;
					dd_offset = off[line_offset_width-1:0];
				end
			end
		repeat (100)
		begin
			begin_cycle();
			random_dd(1'b1);
		end
		finish_test("random loads");

		start_test();
		repeat (400)
		begin
			begin_cycle();
			if (rand_word() % 2)
				random_sx();
			else
				random_dd(1'b0);
		end
		finish_test("rollback priority");

		start_test();
		// Call writes the link register while it rolls back
		begin_cycle();
		sx_valid = 1'b1;
		sx_pc = 32'h100;
		sx_is_call = 1'b1;
		sx_has_dest = 1'b1;
		sx_dest_reg = 5'd30;
		sx_result = 32'h104;
		sx_rollback_en = 1'b1;
		sx_rollback_pc = 32'h2000;
		// Taken branch with a destination writes nothing
		begin_cycle();
		sx_valid = 1'b1;
		sx_has_dest = 1'b1;
		sx_dest_reg = 5'd5;
		sx_result = 32'h55aa_55aa;
		sx_rollback_en = 1'b1;
		sx_rollback_pc = 32'h3000;
		// Missed load writes nothing
		begin_cycle();
		dd_valid = 1'b1;
		dd_is_load = 1'b1;
		dd_has_dest = 1'b1;
		dd_dest_reg = 5'd9;
		dd_rollback_en = 1'b1;
		dd_rollback_pc = 32'h300;
		dd_suspend_thread = 1'b1;
		dd_load_data = rand_line();
		finish_test("rolled-back writes");

		start_test();
		for (int t = 0; t < threads_per_core; t++)
		begin
			// Miss suspends the thread
			begin_cycle();
			dd_valid = 1'b1;
			dd_thread_idx = t[1:0];
			dd_is_load = 1'b1;
			dd_rollback_en = 1'b1;
			dd_rollback_pc = 32'h500 + t;
			dd_suspend_thread = 1'b1;
			// Full store buffer suspends and replays the store
			begin_cycle();
			dd_valid = 1'b1;
			dd_thread_idx = t[1:0];
			dd_rollback_pc = 32'h600 + t;
			sq_full_rollback_en = 1'b1;
		end
		finish_test("thread suspend");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("STATUS: PASS");
		end
		else
		begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
